// ==== Makefile ====
TOP := menu_buttons_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

obj_dir/V$(TOP): files.f rtl/*.sv rtl/*.svh testbench/*.sv
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF 'Finished with no errors'

clean:
	rm -rf obj_dir

// ==== files.f ====
+incdir+rtl
rtl/menu_pkg.sv
rtl/button_regs.sv
rtl/button_font_rom.sv
rtl/button_text_layer.sv
rtl/button_hover_detect.sv
rtl/button_pixel_mixer.sv
rtl/menu_buttons.sv
testbench/menu_buttons_assertions.sv
testbench/menu_buttons_checker.sv
testbench/menu_buttons_tb.sv

// ==== rtl/button_font_rom.sv ====
`default_nettype none

module button_font_rom (
    input  wire  clk,
    input  wire  [$bits(menu_pkg::char_code_t)+$bits(menu_pkg::glyph_row_t)-1:0] addr,
    output menu_pkg::font_line_t line
);

    menu_pkg::char_code_t code;
    menu_pkg::glyph_row_t row;
    logic [55:0]          glyph;
    logic [2:0]           band;
    menu_pkg::font_line_t line_next;

    assign {code, row} = addr;

    // 7 row bitmaps, top row in the upper byte
    always_comb begin
        case (code)
            7'h41:   glyph = {8'h18, 8'h24, 8'h42, 8'h42, 8'h7e, 8'h42, 8'h42};
            7'h45:   glyph = {8'h7e, 8'h40, 8'h40, 8'h7c, 8'h40, 8'h40, 8'h7e};
            7'h49:   glyph = {8'h3c, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18, 8'h3c};
            7'h4c:   glyph = {8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h40, 8'h7e};
            7'h4d:   glyph = {8'h42, 8'h66, 8'h5a, 8'h5a, 8'h42, 8'h42, 8'h42};
            7'h4e:   glyph = {8'h42, 8'h62, 8'h52, 8'h4a, 8'h46, 8'h42, 8'h42};
            7'h50:   glyph = {8'h7c, 8'h42, 8'h42, 8'h7c, 8'h40, 8'h40, 8'h40};
            7'h54:   glyph = {8'h7e, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18};
            7'h55:   glyph = {8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3c};
            7'h59:   glyph = {8'h42, 8'h42, 8'h24, 8'h18, 8'h18, 8'h18, 8'h18};
            7'h20:   glyph = '0;
            default: glyph = '0;
        endcase
    end

    // each bitmap row spans two glyph lines, 1 to 14
    assign band = 3'((row - 4'd1) >> 1);

    always_comb begin
        if (row == 4'd0 || row == 4'd15) begin
            line_next = '0;
        end else begin
            line_next = glyph[8 * (6 - band) +: 8];
        end
    end

    always_ff @(posedge clk) begin
        line <= line_next;
    end

endmodule

`default_nettype wire

// ==== rtl/button_hover_detect.sv ====
`default_nettype none
`include "menu_settings.svh"

module button_hover_detect (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire menu_pkg::pixel_coord_t hcount,
    input  wire menu_pkg::pixel_coord_t vcount,
    input  wire menu_pkg::pixel_coord_t mouse_x,
    input  wire menu_pkg::pixel_coord_t mouse_y,
    output menu_pkg::button_mask_t in_box,
    output menu_pkg::button_mask_t hover
);

    menu_pkg::button_mask_t pix_hit;
    menu_pkg::button_mask_t mouse_hit;
    menu_pkg::button_mask_t pix_hit_q;
    menu_pkg::button_mask_t mouse_hit_q;

    function automatic logic in_rect(
        input menu_pkg::pixel_coord_t x,
        input menu_pkg::pixel_coord_t y,
        input menu_pkg::pixel_coord_t x0,
        input menu_pkg::pixel_coord_t y0
    );
        return (x >= x0) && (x < x0 + `BOX_W) && (y >= y0) && (y < y0 + `BOX_H);
    endfunction

    assign pix_hit   = {in_rect(hcount, vcount, `MENU_X, `MENU_Y),
                        in_rect(hcount, vcount, `MULTI_X, `MULTI_Y),
                        in_rect(hcount, vcount, `PLAY_X, `PLAY_Y)};
    assign mouse_hit = {in_rect(mouse_x, mouse_y, `MENU_X, `MENU_Y),
                        in_rect(mouse_x, mouse_y, `MULTI_X, `MULTI_Y),
                        in_rect(mouse_x, mouse_y, `PLAY_X, `PLAY_Y)};

    // two stages to line up with the font rom read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_hit_q   <= '0;
            mouse_hit_q <= '0;
            in_box      <= '0;
            hover       <= '0;
        end else begin
            pix_hit_q   <= pix_hit;
            mouse_hit_q <= mouse_hit;
            in_box      <= pix_hit_q;
            hover       <= mouse_hit_q;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/button_pixel_mixer.sv ====
`default_nettype none
`include "menu_settings.svh"

module button_pixel_mixer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire menu_pkg::pixel_coord_t hcount,
    input  wire menu_pkg::pixel_coord_t vcount,
    input  wire                    hsync,
    input  wire                    vsync,
    input  wire                    hblnk,
    input  wire                    vblnk,
    input  wire menu_pkg::rgb_t    rgb_in,
    input  wire                    text_on,
    input  wire menu_pkg::button_mask_t in_box,
    input  wire menu_pkg::button_mask_t hover,
    input  wire menu_pkg::button_mask_t enable,
    input  wire menu_pkg::rgb_t    fill_color,
    input  wire menu_pkg::rgb_t    hover_color,
    input  wire menu_pkg::rgb_t    text_color,
    output menu_pkg::pixel_coord_t hcount_out,
    output menu_pkg::pixel_coord_t vcount_out,
    output logic                   hsync_out,
    output logic                   vsync_out,
    output logic                   hblnk_out,
    output logic                   vblnk_out,
    output menu_pkg::rgb_t         rgb_out
);

    // the output register adds the last cycle
    localparam int DLY = `PIPE_LAT - 1;

    menu_pkg::pixel_coord_t hcount_d [DLY];
    menu_pkg::pixel_coord_t vcount_d [DLY];
    menu_pkg::rgb_t         rgb_d    [DLY];
    logic [DLY-1:0]         hsync_d;
    logic [DLY-1:0]         vsync_d;
    logic [DLY-1:0]         hblnk_d;
    logic [DLY-1:0]         vblnk_d;
    logic                   box_hit;
    logic                   sel_hover;
    menu_pkg::rgb_t         mix_rgb;

    always_ff @(posedge clk) begin
        hcount_d[0] <= hcount;
        vcount_d[0] <= vcount;
        rgb_d[0]    <= rgb_in;
        for (int i = 1; i < DLY; i++) begin
            hcount_d[i] <= hcount_d[i-1];
            vcount_d[i] <= vcount_d[i-1];
            rgb_d[i]    <= rgb_d[i-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync_d <= '0;
            vsync_d <= '0;
            hblnk_d <= '0;
            vblnk_d <= '0;
        end else begin
            hsync_d <= {hsync_d[DLY-2:0], hsync};
            vsync_d <= {vsync_d[DLY-2:0], vsync};
            hblnk_d <= {hblnk_d[DLY-2:0], hblnk};
            vblnk_d <= {vblnk_d[DLY-2:0], vblnk};
        end
    end

    // walk down so the lowest enabled box wins
    always_comb begin
        box_hit   = 1'b0;
        sel_hover = 1'b0;
        for (int i = $bits(menu_pkg::button_mask_t) - 1; i >= 0; i--) begin
            if (in_box[i] && enable[i]) begin
                box_hit   = 1'b1;
                sel_hover = hover[i];
            end
        end
        if (hblnk_d[DLY-1] || vblnk_d[DLY-1] || !box_hit) begin
            mix_rgb = rgb_d[DLY-1];
        end else if (text_on) begin
            mix_rgb = text_color;
        end else if (sel_hover) begin
            mix_rgb = hover_color;
        end else begin
            mix_rgb = fill_color;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= hcount_d[DLY-1];
            vcount_out <= vcount_d[DLY-1];
            hsync_out  <= hsync_d[DLY-1];
            vsync_out  <= vsync_d[DLY-1];
            hblnk_out  <= hblnk_d[DLY-1];
            vblnk_out  <= vblnk_d[DLY-1];
            rgb_out    <= mix_rgb;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/button_regs.sv ====
`default_nettype none
`include "menu_settings.svh"

module button_regs (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire  [3:0]             paddr,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire  [11:0]            pwdata,
    output logic [11:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output menu_pkg::button_mask_t enable,
    output menu_pkg::rgb_t         fill_color,
    output menu_pkg::rgb_t         hover_color,
    output menu_pkg::rgb_t         text_color
);

    logic access;
    logic mapped;

    assign access = psel && penable;
    assign mapped = (paddr == `REG_CTRL) || (paddr == `REG_FILL) ||
                    (paddr == `REG_HOVER) || (paddr == `REG_TEXT);

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable      <= '0;
            fill_color  <= `FILL_RST;
            hover_color <= `HOVER_RST;
            text_color  <= `TEXT_RST;
        end else if (access && pwrite) begin
            case (paddr)
                `REG_CTRL:  enable      <= pwdata[$bits(menu_pkg::button_mask_t)-1:0];
                `REG_FILL:  fill_color  <= pwdata;
                `REG_HOVER: hover_color <= pwdata;
                `REG_TEXT:  text_color  <= pwdata;
                default:    ;
            endcase
        end
    end

    // unmapped reads return zero
    always_comb begin
        case (paddr)
            `REG_CTRL:  prdata = 12'(enable);
            `REG_FILL:  prdata = fill_color;
            `REG_HOVER: prdata = hover_color;
            `REG_TEXT:  prdata = text_color;
            default:    prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/button_text_layer.sv ====
`default_nettype none
`include "menu_settings.svh"

module button_text_layer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire menu_pkg::pixel_coord_t hcount,
    input  wire menu_pkg::pixel_coord_t vcount,
    output logic                   text_on
);

    // five ascii characters, leftmost cell in the top byte
    localparam logic [39:0] PLAY_LABEL  = "PLAY ";
    localparam logic [39:0] MULTI_LABEL = "MULTI";
    localparam logic [39:0] MENU_LABEL  = "MENU ";

    logic                   hit;
    menu_pkg::pixel_coord_t org_x;
    menu_pkg::pixel_coord_t org_y;
    logic [39:0]            label;
    menu_pkg::pixel_coord_t rel_x;
    menu_pkg::pixel_coord_t rel_y;
    menu_pkg::char_code_t   code;

    logic                   s1_hit;
    menu_pkg::char_code_t   s1_code;
    menu_pkg::glyph_row_t   s1_row;
    logic [2:0]             s1_col;
    logic                   s2_hit;
    logic [2:0]             s2_col;
    menu_pkg::font_line_t   font_line;

    function automatic logic in_strip(
        input menu_pkg::pixel_coord_t x,
        input menu_pkg::pixel_coord_t y,
        input menu_pkg::pixel_coord_t x0,
        input menu_pkg::pixel_coord_t y0
    );
        return (x >= x0 + `TEXT_X_OFF) && (x < x0 + `TEXT_X_OFF + `TEXT_W) &&
               (y >= y0 + `TEXT_Y_OFF) && (y < y0 + `TEXT_Y_OFF + `TEXT_H);
    endfunction

    // boxes never overlap, order only picks one
    always_comb begin
        hit   = 1'b0;
        org_x = `PLAY_X;
        org_y = `PLAY_Y;
        label = PLAY_LABEL;
        if (in_strip(hcount, vcount, `PLAY_X, `PLAY_Y)) begin
            hit = 1'b1;
        end else if (in_strip(hcount, vcount, `MULTI_X, `MULTI_Y)) begin
            hit   = 1'b1;
            org_x = `MULTI_X;
            org_y = `MULTI_Y;
            label = MULTI_LABEL;
        end else if (in_strip(hcount, vcount, `MENU_X, `MENU_Y)) begin
            hit   = 1'b1;
            org_x = `MENU_X;
            org_y = `MENU_Y;
            label = MENU_LABEL;
        end
    end

    assign rel_x = hcount - org_x - `TEXT_X_OFF;
    assign rel_y = vcount - org_y - `TEXT_Y_OFF;

    // cell number sits above the 3 column bits
    always_comb begin
        case (rel_x[5:3])
            3'd0:    code = label[38:32];
            3'd1:    code = label[30:24];
            3'd2:    code = label[22:16];
            3'd3:    code = label[14:8];
            3'd4:    code = label[6:0];
            default: code = 7'h20;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_hit <= 1'b0;
            s2_hit <= 1'b0;
        end else begin
            s1_hit <= hit;
            s2_hit <= s1_hit;
        end
    end

    always_ff @(posedge clk) begin
        s1_code <= code;
        s1_row  <= rel_y[3:0];
        s1_col  <= rel_x[2:0];
        s2_col  <= s1_col;
    end

    button_font_rom u_font_rom (
        .clk  (clk),
        .addr ({s1_code, s1_row}),
        .line (font_line)
    );

    // column 0 is the msb
    assign text_on = s2_hit && font_line[3'd7 - s2_col];

endmodule

`default_nettype wire

// ==== rtl/menu_buttons.sv ====
`default_nettype none

module menu_buttons (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire  [3:0]             paddr,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire  [11:0]            pwdata,
    output logic [11:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  wire menu_pkg::pixel_coord_t hcount,
    input  wire menu_pkg::pixel_coord_t vcount,
    input  wire                    hsync,
    input  wire                    vsync,
    input  wire                    hblnk,
    input  wire                    vblnk,
    input  wire menu_pkg::rgb_t    rgb_in,
    input  wire menu_pkg::pixel_coord_t mouse_x,
    input  wire menu_pkg::pixel_coord_t mouse_y,
    output menu_pkg::pixel_coord_t hcount_out,
    output menu_pkg::pixel_coord_t vcount_out,
    output logic                   hsync_out,
    output logic                   vsync_out,
    output logic                   hblnk_out,
    output logic                   vblnk_out,
    output menu_pkg::rgb_t         rgb_out
);

    menu_pkg::button_mask_t enable;
    menu_pkg::rgb_t         fill_color;
    menu_pkg::rgb_t         hover_color;
    menu_pkg::rgb_t         text_color;
    logic                   text_on;
    menu_pkg::button_mask_t in_box;
    menu_pkg::button_mask_t hover;

    button_regs u_button_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .enable      (enable),
        .fill_color  (fill_color),
        .hover_color (hover_color),
        .text_color  (text_color)
    );

    // text and hover paths run in parallel, both 2 cycles
    button_text_layer u_text_layer (
        .clk     (clk),
        .rst_n   (rst_n),
        .hcount  (hcount),
        .vcount  (vcount),
        .text_on (text_on)
    );

    button_hover_detect u_hover_detect (
        .clk     (clk),
        .rst_n   (rst_n),
        .hcount  (hcount),
        .vcount  (vcount),
        .mouse_x (mouse_x),
        .mouse_y (mouse_y),
        .in_box  (in_box),
        .hover   (hover)
    );

    button_pixel_mixer u_pixel_mixer (
        .clk         (clk),
        .rst_n       (rst_n),
        .hcount      (hcount),
        .vcount      (vcount),
        .hsync       (hsync),
        .vsync       (vsync),
        .hblnk       (hblnk),
        .vblnk       (vblnk),
        .rgb_in      (rgb_in),
        .text_on     (text_on),
        .in_box      (in_box),
        .hover       (hover),
        .enable      (enable),
        .fill_color  (fill_color),
        .hover_color (hover_color),
        .text_color  (text_color),
        .hcount_out  (hcount_out),
        .vcount_out  (vcount_out),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .hblnk_out   (hblnk_out),
        .vblnk_out   (vblnk_out),
        .rgb_out     (rgb_out)
    );

endmodule

`default_nettype wire

// ==== rtl/menu_pkg.sv ====
`default_nettype none

package menu_pkg;

    // screen coordinate or pixel counter
    typedef logic [11:0] pixel_coord_t;

    // 4:4:4 colour
    typedef logic [11:0] rgb_t;

    // font rom character index
    typedef logic [6:0] char_code_t;

    // one glyph row, msb drawn leftmost
    typedef logic [7:0] font_line_t;

    // line inside a 16 line glyph
    typedef logic [3:0] glyph_row_t;

    // bit 0 play, bit 1 multi, bit 2 menu
    typedef logic [2:0] button_mask_t;

endpackage

`default_nettype wire

// ==== rtl/menu_settings.svh ====
`ifndef MENU_SETTINGS_SVH
`define MENU_SETTINGS_SVH

// box origins on screen
`define PLAY_X      12'd432
`define PLAY_Y      12'd400
`define MULTI_X     12'd432
`define MULTI_Y     12'd640
`define MENU_X      12'd432
`define MENU_Y      12'd520

`define BOX_W       12'd128
`define BOX_H       12'd80

// label strip inside a box, 5 cells of 8 pixels
`define TEXT_X_OFF  12'd44
`define TEXT_Y_OFF  12'd32
`define TEXT_W      12'd40
`define TEXT_H      12'd16

`define FILL_RST    12'h246
`define HOVER_RST   12'h48c
`define TEXT_RST    12'hfff

// apb register map
`define REG_CTRL    4'h0
`define REG_FILL    4'h4
`define REG_HOVER   4'h8
`define REG_TEXT    4'hc

// input pixel to output pixel
`define PIPE_LAT    3

`endif

// ==== testbench/menu_buttons_assertions.sv ====
`default_nettype none

module menu_buttons_assertions (
    input wire        clk,
    input wire        rst_n,
    input wire        psel,
    input wire        penable,
    input wire        pslverr,
    input wire        hsync_out,
    input wire        vsync_out,
    input wire        hblnk_out,
    input wire        vblnk_out,
    input wire [11:0] hcount_out,
    input wire [11:0] vcount_out,
    input wire [11:0] rgb_out
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    // setup phase is always followed by access
    assert property (@(posedge clk) disable iff (!rst_n)
        psel && !penable |=> psel && penable)
        else begin
            $error("setup phase not followed by access phase");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
        else begin
            $error("penable without psel");
            failures++;
        end

    assert property (@(posedge clk) pslverr |-> psel && penable)
        else begin
            $error("pslverr outside access phase");
            failures++;
        end

    // sampled mid cycle, after the first clock has passed the reset
    assert property (@(negedge clk) !rst_n |->
        !hsync_out && !vsync_out && !hblnk_out && !vblnk_out &&
        hcount_out == 12'd0 && vcount_out == 12'd0 && rgb_out == 12'd0)
        else begin
            $error("outputs not cleared during reset");
            failures++;
        end

endmodule

bind menu_buttons menu_buttons_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pslverr    (pslverr),
    .hsync_out  (hsync_out),
    .vsync_out  (vsync_out),
    .hblnk_out  (hblnk_out),
    .vblnk_out  (vblnk_out),
    .hcount_out (hcount_out),
    .vcount_out (vcount_out),
    .rgb_out    (rgb_out)
);

`default_nettype wire

// ==== testbench/menu_buttons_checker.sv ====
`default_nettype none
`include "menu_settings.svh"

module menu_buttons_checker (
    input wire clk,
    input wire rst_n,
    input wire [3:0] paddr,
    input wire psel,
    input wire penable,
    input wire pwrite,
    input wire [11:0] pwdata,
    input wire menu_pkg::pixel_coord_t hcount,
    input wire menu_pkg::pixel_coord_t vcount,
    input wire hsync,
    input wire vsync,
    input wire hblnk,
    input wire vblnk,
    input wire menu_pkg::rgb_t rgb_in,
    input wire menu_pkg::pixel_coord_t mouse_x,
    input wire menu_pkg::pixel_coord_t mouse_y,
    input wire menu_pkg::pixel_coord_t hcount_out,
    input wire menu_pkg::pixel_coord_t vcount_out,
    input wire hsync_out,
    input wire vsync_out,
    input wire hblnk_out,
    input wire vblnk_out,
    input wire menu_pkg::rgb_t rgb_out
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        menu_pkg::pixel_coord_t hc;
        menu_pkg::pixel_coord_t vc;
        logic                   hs;
        logic                   vs;
        logic                   hb;
        logic                   vb;
        menu_pkg::rgb_t         rgb;
        menu_pkg::pixel_coord_t mx;
        menu_pkg::pixel_coord_t my;
    } pixel_t;

    pixel_t                 pipe[$];
    menu_pkg::button_mask_t en_c = '0;
    menu_pkg::rgb_t         fill_c = `FILL_RST;
    menu_pkg::rgb_t         hover_c = `HOVER_RST;
    menu_pkg::rgb_t         text_c = `TEXT_RST;
    int errors = 0;
    int test_errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int text_count[3];
    logic [2:0] strip_seen = '0;

    function automatic menu_pkg::pixel_coord_t org_x(input int b);
        return (b == 0) ? `PLAY_X : (b == 1) ? `MULTI_X : `MENU_X;
    endfunction

    function automatic menu_pkg::pixel_coord_t org_y(input int b);
        return (b == 0) ? `PLAY_Y : (b == 1) ? `MULTI_Y : `MENU_Y;
    endfunction

    function automatic logic inside_box(input menu_pkg::pixel_coord_t x,
                                        input menu_pkg::pixel_coord_t y, input int b);
        return x >= org_x(b) && x < org_x(b) + `BOX_W &&
               y >= org_y(b) && y < org_y(b) + `BOX_H;
    endfunction

    // label strip, glyph rows 1 to 14 only
    function automatic logic in_glyph_rows(input menu_pkg::pixel_coord_t x,
                                           input menu_pkg::pixel_coord_t y, input int b);
        return x >= org_x(b) + 12'd44 && x < org_x(b) + 12'd84 &&
               y >= org_y(b) + 12'd33 && y < org_y(b) + 12'd47;
    endfunction

    // expected colour with the text layer ignored
    function automatic menu_pkg::rgb_t ref_pixel(input pixel_t p, output int box);
        box = -1;
        if (p.hb || p.vb) begin
            return p.rgb;
        end
        for (int b = 0; b < 3; b++) begin
            if (inside_box(p.hc, p.vc, b) && en_c[b]) begin
                box = b;
                return inside_box(p.mx, p.my, b) ? hover_c : fill_c;
            end
        end
        return p.rgb;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_value(input string what, input logic [11:0] got,
                               input logic [11:0] exp);
        if (got !== exp) begin
            report_error($sformatf("%s read %h, expected %h", what, got, exp));
        end
    endtask

    task automatic compare(input pixel_t p);
        menu_pkg::rgb_t exp;
        int box;
        exp = ref_pixel(p, box);
        if ({hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out} !==
            {p.hc, p.vc, p.hs, p.vs, p.hb, p.vb}) begin
            report_error($sformatf("timing outputs wrong for pixel %0d,%0d", p.hc, p.vc));
        end
        if (box >= 0 && in_glyph_rows(p.hc, p.vc, box)) begin
            strip_seen[box] = 1'b1;
            if (rgb_out === text_c) begin
                text_count[box]++;
                return;
            end
        end
        if (rgb_out !== exp) begin
            report_error($sformatf("rgb_out %h, expected %h at %0d,%0d",
                                   rgb_out, exp, p.hc, p.vc));
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            pipe.delete();
        end else begin
            if (pipe.size() == `PIPE_LAT) begin
                compare(pipe.pop_front());
            end
            pipe.push_back({hcount, vcount, hsync, vsync, hblnk, vblnk, rgb_in,
                            mouse_x, mouse_y});
            if (psel && penable && pwrite) begin
                case (paddr)
                    `REG_CTRL:  en_c = pwdata[2:0];
                    `REG_FILL:  fill_c = pwdata;
                    `REG_HOVER: hover_c = pwdata;
                    `REG_TEXT:  text_c = pwdata;
                    default:    ;
                endcase
            end
        end
    end

    // every enabled strip shows part of its label in each frame
    task automatic check_labels();
        for (int b = 0; b < 3; b++) begin
            if (strip_seen[b] && text_count[b] == 0) begin
                $display("box %0d showed no label pixels in a frame", b);
                errors++;
                test_errors++;
            end
            text_count[b] = 0;
        end
        strip_seen = '0;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: FAIL, %0d errors", name, test_errors);
            failed_tests++;
        end
        test_errors = 0;
    endtask

    task automatic print_counts();
        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
    endtask

endmodule

`default_nettype wire

// ==== testbench/menu_buttons_tb.sv ====
`default_nettype none
`include "menu_settings.svh"

module menu_buttons_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LIMIT = 100;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic [3:0] paddr = '0;
    logic psel = 1'b0;
    logic penable = 1'b0;
    logic pwrite = 1'b0;
    logic [11:0] pwdata = '0;
    logic [11:0] prdata;
    logic pready;
    logic pslverr;
    menu_pkg::pixel_coord_t hcount = '0;
    menu_pkg::pixel_coord_t vcount = '0;
    logic hsync = 1'b0;
    logic vsync = 1'b0;
    logic hblnk = 1'b1;
    logic vblnk = 1'b0;
    menu_pkg::rgb_t rgb_in = '0;
    menu_pkg::pixel_coord_t mouse_x = '0;
    menu_pkg::pixel_coord_t mouse_y = '0;
    menu_pkg::pixel_coord_t hcount_out;
    menu_pkg::pixel_coord_t vcount_out;
    logic hsync_out;
    logic vsync_out;
    logic hblnk_out;
    logic vblnk_out;
    menu_pkg::rgb_t rgb_out;

    logic [11:0] rdata;
    logic rerr;
    logic [11:0] wvals[4];
    logic [2:0] en;

    always #2 clk = ~clk;

    menu_buttons u_menu_buttons (.*);

    menu_buttons_checker u_checker (.*);

    task automatic give_up(input string what);
        $display("timeout waiting for %s", what);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic apb_access(input logic [3:0] addr, input logic wr,
                              input logic [11:0] data);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        psel = 1'b1;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        do begin
            @(posedge clk);
            n++;
        end while (!pready && n < LIMIT);
        if (!pready) begin
            give_up("pready");
        end else begin
            rdata = prdata;
            rerr = pslverr;
            #1;
            psel = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [11:0] exp);
        apb_access(addr, 1'b0, '0);
        u_checker.check_value($sformatf("register %h", addr), rdata, exp);
        u_checker.check_value("pslverr", 12'(rerr), 12'd0);
    endtask

    // window around the boxes, blanking gap after every line
    task automatic scan_frame();
        int n;
        for (menu_pkg::pixel_coord_t y = 12'd390; y < 12'd730; y++) begin
            for (menu_pkg::pixel_coord_t x = 12'd420; x < 12'd580; x++) begin
                @(posedge clk);
                #1;
                hcount = x;
                vcount = y;
                hblnk = x >= 12'd572;
                hsync = x >= 12'd574 && x < 12'd578;
                rgb_in = 12'($urandom);
            end
        end
        @(posedge clk);
        #1;
        vblnk = 1'b1;
        vsync = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!vblnk_out && n < LIMIT);
        if (!vblnk_out) begin
            give_up("end of frame");
        end else begin
            #1;
            vsync = 1'b0;
            vblnk = 1'b0;
            hblnk = 1'b1;
            u_checker.check_labels();
        end
    endtask

    initial begin
        void'($urandom(32'he481));
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        read_check(`REG_CTRL, 12'd0);
        read_check(`REG_FILL, `FILL_RST);
        read_check(`REG_HOVER, `HOVER_RST);
        read_check(`REG_TEXT, `TEXT_RST);
        scan_frame();
        u_checker.end_test("reset passthrough");

        for (int i = 0; i < 4; i++) begin
            wvals[i] = 12'($urandom);
            apb_access(4'(4 * i), 1'b1, wvals[i]);
        end
        read_check(`REG_CTRL, {9'd0, wvals[0][2:0]});
        read_check(`REG_FILL, wvals[1]);
        read_check(`REG_HOVER, wvals[2]);
        read_check(`REG_TEXT, wvals[3]);
        apb_access(4'h2, 1'b0, '0);
        u_checker.check_value("unmapped pslverr", 12'(rerr), 12'd1);
        u_checker.check_value("unmapped read", rdata, 12'd0);
        u_checker.end_test("register access");

        apb_access(`REG_CTRL, 1'b1, 12'd7);
        scan_frame();
        u_checker.end_test("fill and labels");

        // mouse inside PLAY, then MULTI, then MENU
        mouse_x = `PLAY_X + 12'($urandom % 128);
        mouse_y = `PLAY_Y + 12'($urandom % 80);
        scan_frame();
        mouse_x = `MULTI_X + 12'($urandom % 128);
        mouse_y = `MULTI_Y + 12'($urandom % 80);
        scan_frame();
        mouse_x = `MENU_X + 12'($urandom % 128);
        mouse_y = `MENU_Y + 12'($urandom % 80);
        scan_frame();
        u_checker.end_test("hover");

        repeat (3) begin
            en = 3'($urandom);
            apb_access(`REG_CTRL, 1'b1, {9'd0, en});
            scan_frame();
        end
        u_checker.end_test("enable mask");

        u_checker.print_counts();
        if (u_checker.errors == 0 && u_menu_buttons.u_assertions.failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
